//--- src/csr_pkg.sv
package csr_pkg;

    // Machine-mode CSR address, as carried in the low bits of operand 2
    typedef logic [11:0] csr_addr_t;

    // Access codes of the CSR instructions
    // CSR_READ reads without writing, which is what the read-only counters accept
    typedef enum logic [1:0] {
        CSR_SWAP  = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2,
        CSR_READ  = 2'd3
    } csr_op_t;

    // Read/write machine registers
    localparam csr_addr_t MSTATUS  = 12'h300;
    localparam csr_addr_t MSCRATCH = 12'h340;

    // Read-only counters, in the machine counter space
    localparam csr_addr_t MCYCLE   = 12'hB00;
    localparam csr_addr_t MINSTRET = 12'hB02;

    // Global machine interrupt enable inside MSTATUS
    localparam int unsigned MSTATUS_MIE = 3;

endpackage : csr_pkg

//--- src/exu_pkg.sv
package exu_pkg;

    import csr_pkg::*;

    // Machine word moved on every lane
    typedef logic [31:0] data_word_t;

    // Lane index of each unit in the result, packet and valid arrays
    typedef enum logic [1:0] {
        ITU = 2'd0,
        LSU = 2'd1,
        CSR = 2'd2
    } exu_unit_t;

    // Integer unit operations, all eight codes are in use
    typedef enum logic [2:0] {
        ITU_ADD, ITU_SUB, ITU_AND, ITU_OR, ITU_XOR, ITU_SLL, ITU_SRL, ITU_SLT
    } itu_op_t;

    // Load/store unit operations, word accesses only
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } lsu_op_t;

    // One 3-bit operation field, read through the view of the selected lane
    // The narrower codes sit in the low bits with padding above
    typedef union packed {
        itu_op_t itu;
        struct packed {
            logic [1:0] unused;
            lsu_op_t    op;
        } lsu;
        struct packed {
            logic       unused;
            csr_op_t    op;
        } csr;
    } exu_op_t;

    // Exception causes, numbered as the machine cause register would report them
    typedef enum logic [3:0] {
        NONE             = 4'd0,
        ILLEGAL_INSTR    = 4'd2,
        LOAD_MISALIGNED  = 4'd4,
        STORE_MISALIGNED = 4'd6
    } exc_cause_t;

    // Instruction packet that follows the operation through its unit
    typedef struct packed {
        logic [3:0] tag;
        logic       exception_generated;
        exc_cause_t exception_vector;
    } instr_packet_t;

endpackage : exu_pkg

//--- src/mem_port_if.sv
interface mem_port_if
    import exu_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 64
) ();

    // Request strobe, the access happens at the edge where it is high
    logic                         req;
    // Write when high, read otherwise
    logic                         we;
    // Word index into the scratchpad
    logic [$clog2(MEM_WORDS)-1:0] addr;
    data_word_t                   wdata;
    // Read data, valid in the cycle after a read request
    data_word_t                   rdata;

    modport lsu (output req, output we, output addr, output wdata, input rdata);

    modport mem (input req, input we, input addr, input wdata, output rdata);

endinterface : mem_port_if

//--- src/integer_unit.sv
module integer_unit
    import exu_pkg::*;
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          valid_i,
    input  itu_op_t       operation_i,
    input  data_word_t    operand_1_i,
    input  data_word_t    operand_2_i,
    input  instr_packet_t ipacket_i,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          valid_o
);

    data_word_t result_d;

    // Only the low five bits of operand 2 count as shift amount
    logic [4:0] shamt;

    assign shamt = operand_2_i[4:0];

    always_comb begin
        result_d = '0;
        case (operation_i)
            ITU_ADD: result_d = operand_1_i + operand_2_i;
            ITU_SUB: result_d = operand_1_i - operand_2_i;
            ITU_AND: result_d = operand_1_i & operand_2_i;
            ITU_OR:  result_d = operand_1_i | operand_2_i;
            ITU_XOR: result_d = operand_1_i ^ operand_2_i;
            ITU_SLL: result_d = operand_1_i << shamt;
            // Logical shift, zeros come in from the top
            ITU_SRL: result_d = operand_1_i >> shamt;
            // Signed compare, the flag lands in bit 0
            ITU_SLT: result_d = data_word_t'($signed(operand_1_i) < $signed(operand_2_i));
            default: result_d = '0;
        endcase
    end

    // Result and packet are only loaded for an issued operation
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o  <= result_d;
            ipacket_o <= ipacket_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // The lane strobe must stay defined once out of reset
    assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown(valid_o))
        else $error("Integer unit valid is unknown");

endmodule : integer_unit

//--- src/load_store_unit.sv
module load_store_unit
    import exu_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 64
) (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          valid_i,
    input  lsu_op_t       operation_i,
    input  data_word_t    address_i,
    input  data_word_t    data_i,
    input  instr_packet_t ipacket_i,
    mem_port_if.lsu       mem_port,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          valid_o
);

    // Byte address bits above the word offset that select a scratchpad word
    localparam int unsigned INDEX_BITS = $clog2(MEM_WORDS);

    logic          misaligned;
    logic          load_q;
    instr_packet_t packet_d;

    // Word accesses need the two low address bits clear
    assign misaligned = (address_i[1:0] != 2'b00);

    // The request goes out in the issue cycle, so the access happens at its closing edge
    // Upper address bits are dropped and the index wraps over the scratchpad
    assign mem_port.req   = valid_i && !misaligned;
    assign mem_port.we    = (operation_i == STORE);
    assign mem_port.addr  = address_i[INDEX_BITS+1:2];
    assign mem_port.wdata = data_i;

    // Mark the packet with the cause that matches the access direction
    always_comb begin
        packet_d = ipacket_i;
        if (misaligned) begin
            packet_d.exception_generated = 1'b1;
            if (operation_i == LOAD) begin
                packet_d.exception_vector = LOAD_MISALIGNED;
            end else begin
                packet_d.exception_vector = STORE_MISALIGNED;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            ipacket_o <= packet_d;
        end
    end

    // load_q remembers that the word coming back on rdata belongs to this lane
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            load_q  <= mem_port.req && !mem_port.we;
        end
    end

    // Stores and rejected accesses return zero
    assign result_o = load_q ? mem_port.rdata : '0;

    assert property (@(posedge clk_i) disable iff (reset_i)
        mem_port.req |-> (address_i[1:0] == 2'b00))
        else $error("Scratchpad request on a misaligned address");

endmodule : load_store_unit

//--- src/data_scratchpad.sv
module data_scratchpad
    import exu_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 64
) (
    input logic     clk_i,
    mem_port_if.mem mem_port
);

    // Word storage, its content is undefined until written
    data_word_t mem_q [MEM_WORDS];

    // Single port, so a request is either a write or a read, never both
    // A write leaves rdata holding the word of the last read
    always_ff @(posedge clk_i) begin
        if (mem_port.req) begin
            if (mem_port.we) begin
                mem_q[mem_port.addr] <= mem_port.wdata;
            end else begin
                mem_port.rdata <= mem_q[mem_port.addr];
            end
        end
    end

    // The index field is wider than needed when the depth is not a power of two
    assert property (@(posedge clk_i) mem_port.req |-> (mem_port.addr < MEM_WORDS))
        else $error("Scratchpad index out of range");

endmodule : data_scratchpad

//--- src/control_status_registers.sv
module control_status_registers
    import exu_pkg::*;
    import csr_pkg::*;
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          valid_i,
    input  csr_op_t       operation_i,
    input  csr_addr_t     csr_address_i,
    input  data_word_t    csr_data_i,
    input  instr_packet_t ipacket_i,
    input  logic          instr_retired_i,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          valid_o,
    output logic          glb_interrupt_enable_o
);

    data_word_t mstatus_q, mscratch_q, mcycle_q, minstret_q;
    data_word_t read_value, write_value;
    logic       known_address, read_only, illegal, write_en;

    // ========================================
    // Address decode and read-modify-write
    // ========================================

    always_comb begin
        read_value    = '0;
        known_address = 1'b1;
        read_only     = 1'b0;
        case (csr_address_i)
            MSTATUS:  read_value = mstatus_q;
            MSCRATCH: read_value = mscratch_q;
            MCYCLE: begin
                read_value = mcycle_q;
                read_only  = 1'b1;
            end
            MINSTRET: begin
                read_value = minstret_q;
                read_only  = 1'b1;
            end
            default:  known_address = 1'b0;
        endcase
    end

    // New value built from the operand and the current content
    always_comb begin
        case (operation_i)
            CSR_SWAP:  write_value = csr_data_i;
            CSR_SET:   write_value = read_value | csr_data_i;
            CSR_CLEAR: write_value = read_value & ~csr_data_i;
            default:   write_value = read_value;
        endcase
    end

    // Counters only accept a plain read
    assign illegal  = !known_address || (read_only && (operation_i != CSR_READ));
    assign write_en = valid_i && !illegal && (operation_i != CSR_READ);

    // ========================================
    // Register file and counters
    // ========================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mscratch_q <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            // free running, so a read sees the count before this cycle's step
            mcycle_q <= mcycle_q + 1'b1;
            if (instr_retired_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
            if (write_en && (csr_address_i == MSTATUS)) begin
                mstatus_q <= write_value;
            end
            if (write_en && (csr_address_i == MSCRATCH)) begin
                mscratch_q <= write_value;
            end
        end
    end

    assign glb_interrupt_enable_o = mstatus_q[MSTATUS_MIE];

    // ========================================
    // Result lane
    // ========================================

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o  <= illegal ? '0 : read_value;
            ipacket_o <= ipacket_i;
            if (illegal) begin
                ipacket_o.exception_generated <= 1'b1;
                ipacket_o.exception_vector    <= ILLEGAL_INSTR;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Without an issued access the writable registers hold their value
    assert property (@(posedge clk_i) disable iff (reset_i)
        !valid_i |=> ($stable(mstatus_q) && $stable(mscratch_q)))
        else $error("CSR changed without an issued access");

endmodule : control_status_registers

//--- src/execution_unit.sv
module execution_unit
    import exu_pkg::*;
    import csr_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 64
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,
    // One-hot lane select, indexed by exu_unit_t
    input  logic [2:0]          valid_i,
    input  exu_op_t             operation_i,
    input  data_word_t          operand_1_i,
    input  data_word_t          operand_2_i,
    input  instr_packet_t       ipacket_i,
    input  logic                instr_retired_i,
    output data_word_t [2:0]    result_o,
    output instr_packet_t [2:0] ipacket_o,
    output logic [2:0]          valid_o,
    output logic                glb_interrupt_enable_o
);

    // A flushed operation never reaches its unit
    logic [2:0] issue;

    assign issue = flush_i ? 3'b000 : valid_i;

    mem_port_if #(.MEM_WORDS(MEM_WORDS)) mem_port ();

    // ========================================
    // Integer unit
    // ========================================

    integer_unit u_itu (
        .clk_i       ( clk_i           ),
        .reset_i     ( reset_i         ),
        .valid_i     ( issue[ITU]      ),
        .operation_i ( operation_i.itu ),
        .operand_1_i ( operand_1_i     ),
        .operand_2_i ( operand_2_i     ),
        .ipacket_i   ( ipacket_i       ),
        .result_o    ( result_o[ITU]   ),
        .ipacket_o   ( ipacket_o[ITU]  ),
        .valid_o     ( valid_o[ITU]    )
    );

    // ========================================
    // Load/store unit and scratchpad
    // ========================================

    // Operand 1 is the byte address, operand 2 the store data
    load_store_unit #(.MEM_WORDS(MEM_WORDS)) u_lsu (
        .clk_i       ( clk_i              ),
        .reset_i     ( reset_i            ),
        .valid_i     ( issue[LSU]         ),
        .operation_i ( operation_i.lsu.op ),
        .address_i   ( operand_1_i        ),
        .data_i      ( operand_2_i        ),
        .ipacket_i   ( ipacket_i          ),
        .mem_port    ( mem_port.lsu       ),
        .result_o    ( result_o[LSU]      ),
        .ipacket_o   ( ipacket_o[LSU]     ),
        .valid_o     ( valid_o[LSU]       )
    );

    data_scratchpad #(.MEM_WORDS(MEM_WORDS)) u_scratchpad (
        .clk_i    ( clk_i        ),
        .mem_port ( mem_port.mem )
    );

    // CSR data comes from operand 1 and the address from the low bits of operand 2
    control_status_registers u_csr (
        .clk_i                  ( clk_i                          ),
        .reset_i                ( reset_i                        ),
        .valid_i                ( issue[CSR]                     ),
        .operation_i            ( operation_i.csr.op             ),
        .csr_address_i          ( csr_addr_t'(operand_2_i[11:0]) ),
        .csr_data_i             ( operand_1_i                    ),
        .ipacket_i              ( ipacket_i                      ),
        .instr_retired_i        ( instr_retired_i                ),
        .result_o               ( result_o[CSR]                  ),
        .ipacket_o              ( ipacket_o[CSR]                 ),
        .valid_o                ( valid_o[CSR]                   ),
        .glb_interrupt_enable_o ( glb_interrupt_enable_o         )
    );

endmodule : execution_unit

//--- dv/tb_execution_unit.sv
module tb_execution_unit
    import exu_pkg::*;
    import csr_pkg::*;
();

    localparam int unsigned MEM_WORDS       = 64;
    localparam int unsigned NUM_OPS         = 2000;
    localparam int unsigned RESET_TIMEOUT   = 64;
    localparam int unsigned WATCHDOG_CYCLES = 4000;

    logic                clk_i;
    logic                reset_i;
    logic                flush_i;
    logic [2:0]          valid_i;
    exu_op_t             operation_i;
    data_word_t          operand_1_i;
    data_word_t          operand_2_i;
    instr_packet_t       ipacket_i;
    logic                instr_retired_i;
    data_word_t [2:0]    result_o;
    instr_packet_t [2:0] ipacket_o;
    logic [2:0]          valid_o;
    logic                glb_interrupt_enable_o;

    // Reference model state, updated at issue time
    data_word_t    mem_m [MEM_WORDS];
    data_word_t    mstatus_m, mscratch_m, minstret_m, cycle_count;
    // What each lane must show in the cycle after the issue
    logic [2:0]    exp_valid;
    data_word_t    exp_result [3];
    instr_packet_t exp_packet [3];
    logic [31:0]   lcg_state = 32'd76554;

    execution_unit #(.MEM_WORDS(MEM_WORDS)) dut_i (
        .clk_i                  ( clk_i                  ),
        .reset_i                ( reset_i                ),
        .flush_i                ( flush_i                ),
        .valid_i                ( valid_i                ),
        .operation_i            ( operation_i            ),
        .operand_1_i            ( operand_1_i            ),
        .operand_2_i            ( operand_2_i            ),
        .ipacket_i              ( ipacket_i              ),
        .instr_retired_i        ( instr_retired_i        ),
        .result_o               ( result_o               ),
        .ipacket_o              ( ipacket_o              ),
        .valid_o                ( valid_o                ),
        .glb_interrupt_enable_o ( glb_interrupt_enable_o )
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // Synchronous reset over the first 16 rising edges
    initial begin
        reset_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #10;
        reset_i = 1'b0;
    end

    // ========================================
    // Failure reporting and compare tasks
    // ========================================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_word(input string name, input data_word_t actual,
                              input data_word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_packet(input string name, input instr_packet_t actual,
                                input instr_packet_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // Stops a run whose main loop no longer advances
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < WATCHDOG_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        fail_run("Simulation ran past its cycle limit without finishing");
    end

    // ========================================
    // Stimulus generation and reference model
    // ========================================

    // Two LCG steps, keeping only the better upper half of each state
    function automatic data_word_t next_random();
        data_word_t value;
        lcg_state     = lcg_state * 32'd1103515245 + 32'd12345;
        value[31:16]  = lcg_state[31:16];
        lcg_state     = lcg_state * 32'd1103515245 + 32'd12345;
        value[15:0]   = lcg_state[31:16];
        return value;
    endfunction

    // Initial scratchpad content, every word differs from its neighbours
    function automatic data_word_t fill_word(input int unsigned index);
        return 32'h5A00_0000 ^ (index * 32'h0001_0203);
    endfunction

    function automatic data_word_t expected_itu(input itu_op_t op, input data_word_t a,
                                                input data_word_t b);
        case (op)
            ITU_ADD: return a + b;
            ITU_SUB: return a - b;
            ITU_AND: return a & b;
            ITU_OR:  return a | b;
            ITU_XOR: return a ^ b;
            ITU_SLL: return a << b[4:0];
            ITU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // One clock step, then the lanes of the last issue are compared
    task automatic next_cycle();
        @(posedge clk_i);
        cycle_count++;
        #10;
        for (int lane = 0; lane < 3; lane++) begin
            check_bit($sformatf("valid_o[%0d]", lane), valid_o[lane], exp_valid[lane]);
            if (exp_valid[lane]) begin
                check_word($sformatf("result_o[%0d]", lane), result_o[lane], exp_result[lane]);
                check_packet($sformatf("ipacket_o[%0d]", lane), ipacket_o[lane],
                             exp_packet[lane]);
            end
        end
        // MIE follows the register content written at the previous edge
        check_bit("glb_interrupt_enable_o", glb_interrupt_enable_o, mstatus_m[MSTATUS_MIE]);
    endtask

    // Drives one cycle of inputs and works out what the lanes must return
    task automatic issue_op(input logic [2:0] lanes, input exu_op_t op, input data_word_t opa,
                            input data_word_t opb, input logic flush, input logic retired);
        instr_packet_t pkt;
        data_word_t    rnd;
        data_word_t    old_value;
        data_word_t    new_value;
        csr_addr_t     addr;
        logic          known;
        logic          read_only;
        int unsigned   idx;
        rnd                     = next_random();
        pkt.tag                 = rnd[3:0];
        pkt.exception_generated = 1'b0;
        pkt.exception_vector    = NONE;
        valid_i                 = lanes;
        operation_i             = op;
        operand_1_i             = opa;
        operand_2_i             = opb;
        ipacket_i               = pkt;
        flush_i                 = flush;
        instr_retired_i         = retired;

        // A flushed operation leaves no trace at all
        exp_valid = flush ? 3'b000 : lanes;
        if (exp_valid[ITU]) begin
            exp_result[ITU] = expected_itu(op.itu, opa, opb);
            exp_packet[ITU] = pkt;
        end
        if (exp_valid[LSU]) begin
            idx             = (opa >> 2) % MEM_WORDS;
            exp_result[LSU] = '0;
            exp_packet[LSU] = pkt;
            if (opa[1:0] != 2'b00) begin
                exp_packet[LSU].exception_generated = 1'b1;
                exp_packet[LSU].exception_vector    =
                    (op.lsu.op == STORE) ? STORE_MISALIGNED : LOAD_MISALIGNED;
            end else if (op.lsu.op == STORE) begin
                mem_m[idx] = opb;
            end else begin
                exp_result[LSU] = mem_m[idx];
            end
        end
        if (exp_valid[CSR]) begin
            addr      = opb[11:0];
            known     = 1'b1;
            read_only = 1'b0;
            old_value = '0;
            case (addr)
                MSTATUS:  old_value = mstatus_m;
                MSCRATCH: old_value = mscratch_m;
                MCYCLE: begin
                    old_value = cycle_count;
                    read_only = 1'b1;
                end
                MINSTRET: begin
                    old_value = minstret_m;
                    read_only = 1'b1;
                end
                default:  known = 1'b0;
            endcase
            exp_packet[CSR] = pkt;
            if (!known || (read_only && op.csr.op != CSR_READ)) begin
                exp_result[CSR]                     = '0;
                exp_packet[CSR].exception_generated = 1'b1;
                exp_packet[CSR].exception_vector    = ILLEGAL_INSTR;
            end else begin
                exp_result[CSR] = old_value;
                case (op.csr.op)
                    CSR_SWAP:  new_value = opa;
                    CSR_SET:   new_value = old_value | opa;
                    CSR_CLEAR: new_value = old_value & ~opa;
                    default:   new_value = old_value;
                endcase
                if (addr == MSTATUS) mstatus_m = new_value;
                if (addr == MSCRATCH) mscratch_m = new_value;
            end
        end
        // The retired count steps after any read in this cycle
        if (retired) begin
            minstret_m++;
        end
    endtask

    task automatic random_op();
        int unsigned lane_pick;
        int unsigned csr_pick;
        logic [2:0]  lanes;
        data_word_t  opa;
        data_word_t  opb;
        csr_addr_t   addr;
        logic        flush;
        logic        retired;
        lane_pick = next_random() % 8;
        flush     = (next_random() % 10) == 0;
        retired   = (next_random() % 2) == 1;
        opa       = next_random();
        opb       = next_random();
        lanes     = 3'b000;
        if (lane_pick < 3) begin
            lanes[ITU] = 1'b1;
        end else if (lane_pick < 5) begin
            lanes[LSU] = 1'b1;
            // Upper address bits are random to exercise the index wrap
            opa = opa & ~32'h3;
            if (next_random() % 8 == 0) begin
                opa = opa | (1 + next_random() % 3);
            end
        end else if (lane_pick < 7) begin
            lanes[CSR] = 1'b1;
            csr_pick   = next_random() % 6;
            case (csr_pick)
                0, 4:    addr = MSTATUS;
                1:       addr = MSCRATCH;
                2:       addr = MCYCLE;
                3:       addr = MINSTRET;
                default: addr = csr_addr_t'(next_random());
            endcase
            opb = (opb & 32'hFFFF_F000) | data_word_t'(addr);
        end
        // Every lane reads its own view out of the same random code
        issue_op(lanes, exu_op_t'(next_random() % 8), opa, opb, flush, retired);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin : main
        int unsigned wait_cycles;
        exu_op_t     store_op;
        flush_i         = 1'b0;
        valid_i         = 3'b000;
        operation_i     = '0;
        operand_1_i     = '0;
        operand_2_i     = '0;
        ipacket_i       = '0;
        instr_retired_i = 1'b0;
        exp_valid       = 3'b000;
        mstatus_m       = '0;
        mscratch_m      = '0;
        minstret_m      = '0;
        cycle_count     = '0;

        wait_cycles = 0;
        while (reset_i !== 1'b0) begin
            @(negedge clk_i);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                fail_run("Timed out waiting for the end of reset");
            end
        end
        check_bit("valid_o[0]", valid_o[0], 1'b0);
        check_bit("valid_o[1]", valid_o[1], 1'b0);
        check_bit("valid_o[2]", valid_o[2], 1'b0);
        check_bit("glb_interrupt_enable_o", glb_interrupt_enable_o, 1'b0);

        // Fill the whole scratchpad so that every load has a known word
        store_op        = '0;
        store_op.lsu.op = STORE;
        for (int w = 0; w < MEM_WORDS; w++) begin
            next_cycle();
            issue_op(3'b001 << LSU, store_op, data_word_t'(w) << 2, fill_word(w), 1'b0, 1'b0);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            next_cycle();
            random_op();
        end
        next_cycle();
        valid_i = 3'b000;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_execution_unit

//--- execution_unit.f
src/csr_pkg.sv
src/exu_pkg.sv
src/mem_port_if.sv
src/integer_unit.sv
src/load_store_unit.sv
src/data_scratchpad.sv
src/control_status_registers.sv
src/execution_unit.sv
dv/tb_execution_unit.sv

//--- Bender.yml
package:
  name: execution_unit

sources:
  - src/csr_pkg.sv
  - src/exu_pkg.sv
  - src/mem_port_if.sv
  - src/integer_unit.sv
  - src/load_store_unit.sv
  - src/data_scratchpad.sv
  - src/control_status_registers.sv
  - src/execution_unit.sv
  - target: test
    files:
      - dv/tb_execution_unit.sv
